// File: common/ddc_pkg.sv
package ddc_pkg;

	localparam int ADC_W          = 16;
	localparam int PHASE_W        = 32;
	localparam int CORDIC_STAGES  = 16;     // also the rotator latency
	localparam int DEC_RATE       = 16;
	localparam int CIC_STAGES     = 3;
	localparam int CIC_W          = 28;     // 16 in + 3 x log2(16) growth
	localparam int FIFO_DEPTH     = 16;     // in I/Q pairs
	localparam int STARTUP_CYCLES = 64;

	localparam logic [6:0] FREQ_ADDR = 7'h01;
	localparam logic [1:0] EP_ADDR   = 2'b10;   // EP6 on the bridge

	// derived counter widths and terminal counts
	localparam int STARTUP_W = $clog2(STARTUP_CYCLES);
	localparam logic [STARTUP_W-1:0] STARTUP_LAST = STARTUP_W'(STARTUP_CYCLES - 1);
	localparam int DEC_W = $clog2(DEC_RATE);
	localparam logic [DEC_W-1:0] DEC_LAST = DEC_W'(DEC_RATE - 1);
	localparam int FIFO_AW = $clog2(FIFO_DEPTH);

	typedef struct packed {
		logic [6:0]         addr;
		logic [PHASE_W-1:0] data;
		logic               stb;    // one cycle per write
	} reg_wr_t;

	typedef struct packed {
		logic signed [ADC_W-1:0] i;
		logic signed [ADC_W-1:0] q;
	} iq_sample_t;

	// atan(2^-k) with a full turn = 2^16
	localparam logic [15:0] atan_table [CORDIC_STAGES] = '{
		16'd8192, 16'd4836, 16'd2555, 16'd1297,
		16'd651,  16'd326,  16'd163,  16'd81,
		16'd41,   16'd20,   16'd10,   16'd5,
		16'd3,    16'd1,    16'd1,    16'd0
	};

endpackage

// File: design/rx_input.sv
`timescale 1ns/10ps

module rx_input (
	input  logic                           ENC_CLK,
	input  logic                           i_arst_n,
	input  logic [ddc_pkg::ADC_W-1:0]      i_da,
	input  ddc_pkg::reg_wr_t               i_reg,
	output logic [ddc_pkg::ADC_W-1:0]      o_adc,
	output logic [ddc_pkg::PHASE_W-1:0]    o_freq,
	output logic                           o_run
);

	logic [ddc_pkg::STARTUP_W-1:0] hold_cnt;    // startup hold-off
	logic                          freq_hit;

	// only the frequency register lives here
	assign freq_hit = i_reg.stb && (i_reg.addr == ddc_pkg::FREQ_ADDR);

	// hold-off, run latches high and stays there
	always_ff @(posedge ENC_CLK or negedge i_arst_n) begin
		if (!i_arst_n) begin
			hold_cnt <= '0;
			o_run    <= 1'b0;
		end else if (!o_run) begin
			hold_cnt <= hold_cnt + 1'b1;
			if (hold_cnt == ddc_pkg::STARTUP_LAST)
				o_run <= 1'b1;  // 64th edge after release
		end
	end

	// adc word buffered every clock
	always_ff @(posedge ENC_CLK) begin
		o_adc <= i_da;
	end

	// frequency word, writes to other addresses ignored
	always_ff @(posedge ENC_CLK or negedge i_arst_n) begin
		if (!i_arst_n)
			o_freq <= '0;
		else if (freq_hit)
			o_freq <= i_reg.data;
	end

	// datapath enable must be monotonic after startup
	a_run_sticky: assert property (
		@(posedge ENC_CLK) disable iff (!i_arst_n)
		o_run |=> o_run
	) else $error("rx_input: run dropped after startup");

endmodule

// File: mixer/nco_mixer.sv
`timescale 1ns/10ps

module nco_mixer (
	input  logic                                ENC_CLK,
	input  logic                                i_arst_n,
	input  logic                                i_run,
	input  logic signed [ddc_pkg::ADC_W-1:0]    i_adc,
	input  logic [ddc_pkg::PHASE_W-1:0]         i_freq,
	output ddc_pkg::iq_sample_t                 o_iq
);

	logic [ddc_pkg::PHASE_W-1:0]         phase_acc;
	logic [15:0]                         ph;          // top 16 phase bits
	logic signed [ddc_pkg::ADC_W+1:0]    adc_ext;     // two guard bits for gain
	logic signed [ddc_pkg::ADC_W+1:0]    x_q [ddc_pkg::CORDIC_STAGES+1];
	logic signed [ddc_pkg::ADC_W+1:0]    y_q [ddc_pkg::CORDIC_STAGES+1];
	logic signed [15:0]                  z_q [ddc_pkg::CORDIC_STAGES];
	logic [ddc_pkg::CORDIC_STAGES:0]     vld;         // vld[k] tracks x_q[k]

	assign ph      = phase_acc[ddc_pkg::PHASE_W-1 -: 16];
	assign adc_ext = i_adc;     // sign extend

	// phase accumulator and valid pipe, both held clear while not running
	always_ff @(posedge ENC_CLK or negedge i_arst_n) begin
		if (!i_arst_n) begin
			phase_acc <= '0;
			vld       <= '0;
		end else if (!i_run) begin
			phase_acc <= '0;
			vld       <= '0;
		end else begin
			phase_acc <= phase_acc + i_freq;
			vld       <= {vld[ddc_pkg::CORDIC_STAGES-1:0], 1'b1};
		end
	end

	// quadrant pre-rotation of (adc, 0) by -90 deg steps
	always_ff @(posedge ENC_CLK) begin
		case (ph[15:14])
			2'b00: begin
				x_q[0] <= adc_ext;
				y_q[0] <= '0;
			end
			2'b01: begin    // -90
				x_q[0] <= '0;
				y_q[0] <= -adc_ext;
			end
			2'b10: begin    // -180
				x_q[0] <= -adc_ext;
				y_q[0] <= '0;
			end
			default: begin  // -270, i.e. +90
				x_q[0] <= '0;
				y_q[0] <= adc_ext;
			end
		endcase
		z_q[0] <= {2'b00, ph[13:0]};    // residual in [0, 90) deg
	end

	// shift-add stages, each turns clockwise while residual is positive
	for (genvar s = 0; s < ddc_pkg::CORDIC_STAGES; s++) begin : g_stage
		always_ff @(posedge ENC_CLK) begin
			if (z_q[s][15]) begin   // overshot, swing back
				x_q[s+1] <= x_q[s] - (y_q[s] >>> s);
				y_q[s+1] <= y_q[s] + (x_q[s] >>> s);
			end else begin
				x_q[s+1] <= x_q[s] + (y_q[s] >>> s);
				y_q[s+1] <= y_q[s] - (x_q[s] >>> s);
			end
		end

		// last stage has no residual to pass on
		if (s < ddc_pkg::CORDIC_STAGES - 1) begin : g_z
			always_ff @(posedge ENC_CLK) begin
				if (z_q[s][15])
					z_q[s+1] <= z_q[s] + $signed(ddc_pkg::atan_table[s]);
				else
					z_q[s+1] <= z_q[s] - $signed(ddc_pkg::atan_table[s]);
			end
		end
	end

	// halve on the way out, gain 1.647 -> ~0.823
	// zeros until the pipe is full so the CICs never see stale data
	assign o_iq = vld[ddc_pkg::CORDIC_STAGES] ?
		ddc_pkg::iq_sample_t'{
			i: x_q[ddc_pkg::CORDIC_STAGES][ddc_pkg::ADC_W:1],
			q: y_q[ddc_pkg::CORDIC_STAGES][ddc_pkg::ADC_W:1]
		} : '0;

endmodule

// File: decim/cic_decimator.sv
`timescale 1ns/10ps

module cic_decimator (
	input  logic                               ENC_CLK,
	input  logic                               i_arst_n,
	input  logic                               i_run,
	input  logic signed [ddc_pkg::ADC_W-1:0]   i_x,
	output logic signed [ddc_pkg::ADC_W-1:0]   o_y,
	output logic                               o_stb
);

	logic signed [ddc_pkg::CIC_W-1:0] integ [ddc_pkg::CIC_STAGES];
	logic signed [ddc_pkg::CIC_W-1:0] dly   [ddc_pkg::CIC_STAGES];     // comb delays, M=1
	logic signed [ddc_pkg::CIC_W-1:0] comb  [ddc_pkg::CIC_STAGES+1];   // comb[0] is integ out
	logic [ddc_pkg::DEC_W-1:0]        rate_cnt;
	logic                             tick;     // decimated-rate enable

	assign tick    = (rate_cnt == ddc_pkg::DEC_LAST);
	assign comb[0] = integ[ddc_pkg::CIC_STAGES-1];

	// comb chain is combinational, sampled only on tick
	for (genvar k = 0; k < ddc_pkg::CIC_STAGES; k++) begin : g_comb
		assign comb[k+1] = comb[k] - dly[k];
	end

	always_ff @(posedge ENC_CLK or negedge i_arst_n) begin
		if (!i_arst_n) begin
			rate_cnt <= '0;
			o_stb    <= 1'b0;
			o_y      <= '0;
			for (int k = 0; k < ddc_pkg::CIC_STAGES; k++) begin
				integ[k] <= '0;
				dly[k]   <= '0;
			end
		end else if (!i_run) begin     // held clear until startup
			rate_cnt <= '0;
			o_stb    <= 1'b0;
			o_y      <= '0;
			for (int k = 0; k < ddc_pkg::CIC_STAGES; k++) begin
				integ[k] <= '0;
				dly[k]   <= '0;
			end
		end else begin
			rate_cnt <= rate_cnt + 1'b1;    // wraps at DEC_RATE
			o_stb    <= tick;
			integ[0] <= integ[0] + ddc_pkg::CIC_W'(i_x);   // sign-extended
			for (int k = 1; k < ddc_pkg::CIC_STAGES; k++)
				integ[k] <= integ[k] + integ[k-1];
			if (tick) begin
				for (int k = 0; k < ddc_pkg::CIC_STAGES; k++)
					dly[k] <= comb[k];
				// R^N = 2^12, top bits give unity DC gain
				o_y <= comb[ddc_pkg::CIC_STAGES][ddc_pkg::CIC_W-1 -: ddc_pkg::ADC_W];
			end
		end
	end

endmodule

// File: usb/sample_fifo.sv
`timescale 1ns/10ps

module sample_fifo (
	input  logic                ENC_CLK,
	input  logic                i_arst_n,
	input  logic                i_wr,
	input  ddc_pkg::iq_sample_t i_data,
	input  logic                i_rd,
	output ddc_pkg::iq_sample_t o_data,
	output logic                o_empty,
	output logic                o_full
);

	ddc_pkg::iq_sample_t          mem [ddc_pkg::FIFO_DEPTH];
	logic [ddc_pkg::FIFO_AW-1:0]  wr_ptr;
	logic [ddc_pkg::FIFO_AW-1:0]  rd_ptr;
	logic [ddc_pkg::FIFO_AW:0]    fill;     // 0..FIFO_DEPTH
	logic                         wr_en;
	logic                         rd_en;

	assign wr_en   = i_wr && !o_full;   // overflow drops the pair
	assign rd_en   = i_rd && !o_empty;
	assign o_empty = (fill == '0);
	assign o_full  = fill[ddc_pkg::FIFO_AW];  // depth is a power of two
	assign o_data  = mem[rd_ptr];             // head word visible before pop

	always_ff @(posedge ENC_CLK) begin
		if (wr_en)
			mem[wr_ptr] <= i_data;
	end

	always_ff @(posedge ENC_CLK or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else begin
			if (wr_en) wr_ptr <= wr_ptr + 1'b1;
			if (rd_en) rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: ;      // both or neither
			endcase
		end
	end

	a_no_underrun: assert property (@(posedge ENC_CLK) disable iff (!i_arst_n)
		i_rd |-> !o_empty) else $error("sample_fifo: pop while empty");
	a_overflow: assert property (@(posedge ENC_CLK) disable iff (!i_arst_n)
		!(i_wr && o_full)) else $warning("sample_fifo: full, pair dropped");

endmodule

// File: usb/fx2_writer.sv
`timescale 1ns/10ps

module fx2_writer (
	input  logic                         ENC_CLK,
	input  logic                         i_arst_n,
	input  logic                         i_empty,
	input  ddc_pkg::iq_sample_t          i_pair,
	input  logic                         i_flagb_n,     // low = endpoint full
	output logic                         o_rd,
	output logic [ddc_pkg::ADC_W-1:0]    o_fd,
	output logic                         o_slwr_n
);

	logic                        send_i;    // Q on the bus now, I goes next
	logic [ddc_pkg::ADC_W-1:0]   i_word;

	// pair start only from idle, with data and room at the bridge
	assign o_rd = !send_i && !i_empty && i_flagb_n;

	always_ff @(posedge ENC_CLK or negedge i_arst_n) begin
		if (!i_arst_n) begin
			send_i   <= 1'b0;
			o_slwr_n <= 1'b1;
			o_fd     <= '0;
		end else if (send_i) begin
			o_fd     <= i_word;     // I always finishes, flag ignored
			o_slwr_n <= 1'b0;
			send_i   <= 1'b0;
		end else if (o_rd) begin
			o_fd     <= i_pair.q;   // Q first
			o_slwr_n <= 1'b0;
			send_i   <= 1'b1;
		end else begin
			o_slwr_n <= 1'b1;
		end
	end

	always_ff @(posedge ENC_CLK) begin
		if (o_rd)
			i_word <= i_pair.i;
	end

	// a Q word only goes out if the bridge had room when the pair began
	a_q_after_room: assert property (@(posedge ENC_CLK) disable iff (!i_arst_n)
		(send_i && !o_slwr_n) |-> $past(i_flagb_n))
		else $error("fx2_writer: Q written into a full endpoint");

endmodule

// File: design/ddc_rx_top.sv
`timescale 1ns/10ps

module ddc_rx_top (
	input  logic                          ENC_CLK,
	input  logic                          i_arst_n,
	input  logic [ddc_pkg::ADC_W-1:0]     i_da,
	input  ddc_pkg::reg_wr_t              i_reg,
	output logic [ddc_pkg::PHASE_W-1:0]   o_freq,
	output logic [ddc_pkg::ADC_W-1:0]     o_fd,
	output logic                          o_slwr_n,
	output logic [1:0]                    o_fifo_adr,
	input  logic                          i_flagb_n
);

	logic [ddc_pkg::ADC_W-1:0]          adc;
	logic                               run;
	ddc_pkg::iq_sample_t                mix_iq;      // baseband at full rate
	logic signed [ddc_pkg::ADC_W-1:0]   dec_i;
	logic signed [ddc_pkg::ADC_W-1:0]   dec_q;
	logic                               dec_stb;     // cic_q strobes on the same clock
	ddc_pkg::iq_sample_t                dec_pair;
	ddc_pkg::iq_sample_t                fifo_pair;
	logic                               fifo_rd;
	logic                               fifo_empty;

	assign o_fifo_adr = ddc_pkg::EP_ADDR;
	assign dec_pair   = ddc_pkg::iq_sample_t'{i: dec_i, q: dec_q};

	rx_input u_rx_input (.ENC_CLK, .i_arst_n, .i_da, .i_reg,
		.o_adc(adc), .o_freq, .o_run(run));

	nco_mixer u_nco_mixer (.ENC_CLK, .i_arst_n, .i_run(run),
		.i_adc(adc), .i_freq(o_freq), .o_iq(mix_iq));

	cic_decimator cic_i (.ENC_CLK, .i_arst_n, .i_run(run),
		.i_x(mix_iq.i), .o_y(dec_i), .o_stb(dec_stb));

	// started together with cic_i so its strobe goes unused
	cic_decimator cic_q (.ENC_CLK, .i_arst_n, .i_run(run),
		.i_x(mix_iq.q), .o_y(dec_q), .o_stb());

	sample_fifo u_sample_fifo (.ENC_CLK, .i_arst_n, .i_wr(dec_stb), .i_data(dec_pair),
		.i_rd(fifo_rd), .o_data(fifo_pair), .o_empty(fifo_empty), .o_full());

	fx2_writer u_fx2_writer (.ENC_CLK, .i_arst_n, .i_empty(fifo_empty),
		.i_pair(fifo_pair), .i_flagb_n, .o_rd(fifo_rd), .o_fd, .o_slwr_n);

endmodule

// File: tb/ddc_rx_tb.sv
`timescale 1ns/10ps

module ddc_rx_tb;

	localparam int CLK_PERIOD   = 4;
	localparam int SETTLE_PAIRS = 4;        // pairs skipped before DC checks while the combs fill
	// rough test lengths in clocks for the watchdog budget
	localparam int T_STARTUP = 200;
	localparam int T_REGS    = 20;
	localparam int T_DC      = 450;
	localparam int T_TONE    = 300;
	localparam int T_BP      = 1300;
	localparam int T_MARGIN  = 500;

	logic                  ENC_CLK;
	logic                  i_arst_n;
	logic [15:0]           i_da;
	ddc_pkg::reg_wr_t      i_reg;
	logic [31:0]           o_freq;
	logic [15:0]           o_fd;
	logic                  o_slwr_n;
	logic [1:0]            o_fifo_adr;
	logic                  i_flagb_n;

	integer                seed;
	int                    err_cnt  = 0;
	int                    test_cnt = 0;
	int                    fail_cnt = 0;
	int                    word_cnt = 0;    // bus words since last reset
	logic                  prev_flagb = 1'b1;   // flag the writer saw at this edge
	logic [15:0]           pend_q;
	logic signed [15:0]    q_words [$];
	logic signed [15:0]    i_words [$];
	logic signed [15:0]    dc_val;

	ddc_rx_top dut0 (.ENC_CLK, .i_arst_n, .i_da, .i_reg, .o_freq, .o_fd, .o_slwr_n,
		.o_fifo_adr, .i_flagb_n);

	initial begin
		ENC_CLK = 1'b0;
		forever #(CLK_PERIOD / 2) ENC_CLK = ~ENC_CLK;
	end

	initial begin
		#((T_STARTUP + T_REGS + T_DC + T_TONE + T_BP + T_MARGIN) * CLK_PERIOD);
		$display("watchdog expired, a test never finished");
		$display("RESULT: FAIL");
		$finish;
	end

	// bus monitor pairs each Q word with the I word after it
	always @(negedge ENC_CLK) begin
		if (!o_slwr_n) begin
			if (word_cnt % 2 == 0) begin
				if (!prev_flagb) begin
					$display("pair %0d started while the bridge reported full", i_words.size());
					err_cnt++;
				end
				pend_q = o_fd;
			end else begin
				q_words.push_back(pend_q);
				i_words.push_back(o_fd);
			end
			word_cnt++;
		end else if (word_cnt % 2 == 1) begin   // I must follow Q directly
			$display("Q word %0d was not followed by its I word", word_cnt - 1);
			err_cnt++;
		end
		prev_flagb = i_flagb_n;
	end

	// 2-cycle reset with the bus idle throughout
	task automatic apply_reset();
		@(posedge ENC_CLK);
		i_arst_n <= 1'b0;
		word_cnt = 0;
		q_words.delete();
		i_words.delete();
		repeat (2) begin
			@(negedge ENC_CLK);
			if (o_slwr_n !== 1'b1 || o_fd !== 16'h0000) begin
				$display("ERR o_slwr_n/o_fd in reset got %h/%h exp 1/0000", o_slwr_n, o_fd);
				err_cnt++;
			end
			@(posedge ENC_CLK);
		end
		i_arst_n <= 1'b1;
	endtask

	task automatic reg_write(input logic [6:0] wr_addr, input logic [31:0] wr_data);
		@(posedge ENC_CLK);
		i_reg <= '{addr: wr_addr, data: wr_data, stb: 1'b1};
		@(posedge ENC_CLK);
		i_reg.stb <= 1'b0;      // single-cycle strobe
	endtask

	task automatic wait_pairs(input int n, input int limit);
		int cyc;
		cyc = 0;
		while (i_words.size() < n && cyc < limit) begin
			@(posedge ENC_CLK);
			cyc++;
		end
		if (i_words.size() < n) begin
			$display("only %0d of %0d pairs arrived in %0d clocks", i_words.size(), n, limit);
			err_cnt++;
		end
	endtask

	// Q near zero and I near 0.823 x input
	task automatic check_dc(input int first);
		real exp_i;
		real tol;
		int  k;
		exp_i = 0.823 * dc_val;
		tol   = 0.02 * (exp_i < 0.0 ? -exp_i : exp_i) + 8.0;
		for (k = first; k < i_words.size(); k++) begin
			if (q_words[k] > 8 || q_words[k] < -8) begin
				$display("ERR o_fd(Q) pair %0d got %h exp 0000 +-8", k, q_words[k]);
				err_cnt++;
			end
			if ($itor(i_words[k]) > exp_i + tol || $itor(i_words[k]) < exp_i - tol) begin
				$display("ERR o_fd(I) pair %0d got %h exp %h", k, i_words[k],
					16'($rtoi(exp_i)));
				err_cnt++;
			end
		end
	endtask

	task automatic finish_test(input string name, input int start_err);
		test_cnt++;
		if (err_cnt == start_err) begin
			$display("test %s: ok", name);
		end else begin
			fail_cnt++;
			$display("test %s: %0d errors", name, err_cnt - start_err);
		end
	endtask

	task automatic test_startup();
		int start_err;
		int cyc;
		start_err = err_cnt;
		apply_reset();
		cyc = 0;
		while (o_slwr_n && cyc < ddc_pkg::STARTUP_CYCLES + 4 * ddc_pkg::DEC_RATE) begin
			@(negedge ENC_CLK);
			cyc++;
		end
		if (o_slwr_n) begin
			$display("no bus write within %0d clocks of reset release", cyc);
			err_cnt++;
		end else if (cyc < ddc_pkg::STARTUP_CYCLES + ddc_pkg::DEC_RATE) begin  // too early
			$display("ERR o_slwr_n first low at clock %h exp >= %h", cyc,
				ddc_pkg::STARTUP_CYCLES + ddc_pkg::DEC_RATE);
			err_cnt++;
		end
		if (o_fifo_adr !== 2'b10) begin     // EP6 select
			$display("ERR o_fifo_adr got %h exp %h", o_fifo_adr, 2'b10);
			err_cnt++;
		end
		finish_test("startup", start_err);
	endtask

	task automatic test_regs();
		int          start_err;
		logic [31:0] val;
		logic [6:0]  addr;
		start_err = err_cnt;
		val = $random(seed);
		reg_write(ddc_pkg::FREQ_ADDR, val);
		@(negedge ENC_CLK);
		if (o_freq !== val) begin
			$display("ERR o_freq got %h exp %h", o_freq, val);
			err_cnt++;
		end
		addr = $random(seed);
		if (addr == ddc_pkg::FREQ_ADDR)
			addr = 7'h7f;       // any other address
		reg_write(addr, ~val);
		@(negedge ENC_CLK);
		if (o_freq !== val) begin
			$display("ERR o_freq after write to %h got %h exp %h", addr, o_freq, val);
			err_cnt++;
		end
		finish_test("registers", start_err);
	endtask

	task automatic test_dc();
		int start_err;
		start_err = err_cnt;
		dc_val = 16'(1000 + {$random(seed)} % 3000);
		if ($random(seed) & 1)
			dc_val = -dc_val;
		@(posedge ENC_CLK);
		i_da <= dc_val;
		apply_reset();          // phase back to zero
		reg_write(ddc_pkg::FREQ_ADDR, 32'h0);
		wait_pairs(SETTLE_PAIRS + 8, 400);
		check_dc(SETTLE_PAIRS);
		finish_test("dc", start_err);
	endtask

	// fs/4 tone where each window holds whole NCO periods
	task automatic test_tone();
		int start_err;
		int p0;
		int k;
		start_err = err_cnt;
		p0 = i_words.size();
		reg_write(ddc_pkg::FREQ_ADDR, 32'h4000_0000);
		wait_pairs(p0 + 12, 14 * ddc_pkg::DEC_RATE);
		for (k = p0 + 6; k < i_words.size(); k++) begin
			if (i_words[k] > 16 || i_words[k] < -16 || q_words[k] > 16 || q_words[k] < -16) begin
				$display("ERR o_fd(I/Q) pair %0d got %h/%h exp 0000 +-16", k, i_words[k],
					q_words[k]);
				err_cnt++;
			end
		end
		finish_test("tone", start_err);
	endtask

	task automatic test_backpressure();
		int start_err;
		int hold;
		int n0;
		start_err = err_cnt;
		apply_reset();          // freq back to 0 with i_da still at dc_val
		wait_pairs(SETTLE_PAIRS + 2, ddc_pkg::STARTUP_CYCLES + 8 * ddc_pkg::DEC_RATE);
		hold = 40 + {$random(seed)} % 360;
		@(negedge ENC_CLK);
		while (o_slwr_n)        // next Q word on the bus
			@(negedge ENC_CLK);
		@(posedge ENC_CLK);
		i_flagb_n <= 1'b0;      // bridge fills while the I word is still due
		repeat (hold) @(posedge ENC_CLK);
		i_flagb_n <= 1'b1;
		if (word_cnt % 2 != 0) begin    // every started pair done by now
			$display("ERR word_cnt at flag release got %h exp an even count", word_cnt);
			err_cnt++;
		end
		n0 = i_words.size();
		wait_pairs(n0 + 8, 12 * ddc_pkg::DEC_RATE);
		check_dc(SETTLE_PAIRS);
		finish_test("backpressure", start_err);
	endtask

	initial begin
		seed = 32'h2edf138f;
		i_arst_n  <= 1'b0;
		i_da      <= '0;
		i_reg     <= '0;
		i_flagb_n <= 1'b1;
		test_startup();
		test_regs();
		test_dc();
		test_tone();
		test_backpressure();
		$display("tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
		if (fail_cnt == 0 && err_cnt == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: build.f
common/ddc_pkg.sv
design/rx_input.sv
mixer/nco_mixer.sv
decim/cic_decimator.sv
usb/sample_fifo.sv
usb/fx2_writer.sv
design/ddc_rx_top.sv
tb/ddc_rx_tb.sv

// File: Bender.yml
package:
  name: ddc_rx

sources:
  - common/ddc_pkg.sv
  - design/rx_input.sv
  - mixer/nco_mixer.sv
  - decim/cic_decimator.sv
  - usb/sample_fifo.sv
  - usb/fx2_writer.sv
  - design/ddc_rx_top.sv
  - target: test
    files:
      - tb/ddc_rx_tb.sv
